//--- Makefile
# Verilator build for the stream interleaver

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= stream_interleaver_tb
RTL_TOP   ?= stream_interleaver
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= test passed

RTL_FILES = design/interleave_pkg.sv \
            design/lane_fifo.sv \
            design/force_robin_merge.sv \
            design/stream_interleaver.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

$(OBJ_DIR)/V$(TB_TOP): $(RTL_FILES) sim/stream_interleaver_tb.sv $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/force_robin_merge.sv
`timescale 1ns/100ps
`default_nettype none

module force_robin_merge (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         lane_valid [interleave_pkg::NUM_LANES],
    output logic                        lane_ready [interleave_pkg::NUM_LANES],
    input  wire interleave_pkg::lane_word_t lane_word [interleave_pkg::NUM_LANES],
    output logic                        out_valid,
    input  wire                         out_ready,
    output interleave_pkg::merged_word_t out_word
);

    // Output stage occupancy
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EMPTY,
        ST_HOLD,
        ST_HOLD_BUF
    } state_t;

    state_t                                state;
    state_t                                state_next;

    logic [interleave_pkg::LANE_W-1:0]     cur_ptr;
    logic [interleave_pkg::LANE_W-1:0]     nxt_ptr;
    logic [interleave_pkg::NUM_LANES-1:0]  ready_mask;
    logic                                  main_ready;

    logic                                  take;
    logic                                  out_fire;
    interleave_pkg::merged_word_t          take_word;
    interleave_pkg::merged_word_t          buf_word;

    function automatic logic [interleave_pkg::LANE_W-1:0] ptr_inc(
        input logic [interleave_pkg::LANE_W-1:0] ptr
    );
        if (32'(ptr) == interleave_pkg::NUM_LANES - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    function automatic logic [interleave_pkg::NUM_LANES-1:0] one_hot(
        input logic [interleave_pkg::LANE_W-1:0] idx
    );
        logic [interleave_pkg::NUM_LANES-1:0] result;
        result      = '0;
        result[idx] = 1'b1;
        return result;
    endfunction

    // Only the lane whose turn it is may see ready
    always_comb begin
        for (int i = 0; i < interleave_pkg::NUM_LANES; i++) begin
            lane_ready[i] = ready_mask[i] & main_ready;
        end
    end

    assign take     = lane_valid[cur_ptr] & ready_mask[cur_ptr] & main_ready;
    assign out_fire = out_valid & out_ready;

    // Stamp the source lane beside the data
    always_comb begin
        take_word.lane = cur_ptr;
        take_word.data = lane_word[cur_ptr].data;
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                state_next = ST_EMPTY;
            end
            ST_EMPTY: begin
                if (take) begin
                    state_next = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (take && !out_fire) begin
                    state_next = ST_HOLD_BUF;
                end else if (!take && out_fire) begin
                    state_next = ST_EMPTY;
                end
            end
            ST_HOLD_BUF: begin
                if (out_fire) begin
                    state_next = ST_HOLD;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Both pointers step together, nxt_ptr stays one lane ahead
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cur_ptr <= '0;
            nxt_ptr <= interleave_pkg::LANE_W'(1);
        end else if (take) begin
            cur_ptr <= ptr_inc(cur_ptr);
            nxt_ptr <= ptr_inc(nxt_ptr);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ready_mask <= '0;
        end else if (state == ST_IDLE) begin
            ready_mask <= one_hot(cur_ptr);
        end else if (take) begin
            ready_mask <= one_hot(nxt_ptr);
        end
    end

    // Stop taking once the buffer holds a word
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            main_ready <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            main_ready <= (state_next == ST_EMPTY) || (state_next == ST_HOLD);
            out_valid  <= (state_next == ST_HOLD) || (state_next == ST_HOLD_BUF);
        end
    end

    // Output register and skid buffer
    always_ff @(posedge clock) begin
        case (state)
            ST_EMPTY: begin
                if (take) begin
                    out_word <= take_word;
                end
            end
            ST_HOLD: begin
                if (take && out_fire) begin
                    out_word <= take_word;
                end else if (take) begin
                    buf_word <= take_word;
                end
            end
            ST_HOLD_BUF: begin
                if (out_fire) begin
                    out_word <= buf_word;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/interleave_pkg.sv
`default_nettype none

package interleave_pkg;

    // Stream geometry
    localparam int NUM_LANES  = 4;
    localparam int LANE_W     = 2;
    localparam int DATA_W     = 16;

    // Entries held by each lane FIFO
    localparam int FIFO_DEPTH = 4;

    // Word carried on each input lane and between the FIFOs and the merger
    typedef struct packed {
        logic [DATA_W-1:0] data;
    } lane_word_t;

    // Merged output word, tagged with the lane it came from
    typedef struct packed {
        logic [LANE_W-1:0] lane;
        logic [DATA_W-1:0] data;
    } merged_word_t;

endpackage

`default_nettype wire

//--- design/lane_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module lane_fifo (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire interleave_pkg::lane_word_t in_word,
    output logic                      out_valid,
    input  wire                       out_ready,
    output interleave_pkg::lane_word_t out_word
);

    // Storage, read side always shows the oldest entry
    interleave_pkg::lane_word_t mem [interleave_pkg::FIFO_DEPTH];

    logic [$clog2(interleave_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(interleave_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(interleave_pkg::FIFO_DEPTH+1)-1:0] count;
    logic [$clog2(interleave_pkg::FIFO_DEPTH+1)-1:0] count_next;
    logic                                            wr_en;
    logic                                            rd_en;

    assign wr_en = in_valid & in_ready;
    assign rd_en = out_valid & out_ready;

    assign out_valid = (count != '0);
    assign out_word  = mem[rd_ptr];

    always_comb begin
        case ({wr_en, rd_en})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    // Ready is registered so it stays low through reset and rises one cycle later
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            in_ready <= 1'b0;
        end else begin
            in_ready <= (32'(count_next) < interleave_pkg::FIFO_DEPTH);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            if (32'(wr_ptr) == interleave_pkg::FIFO_DEPTH - 1) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            if (32'(rd_ptr) == interleave_pkg::FIFO_DEPTH - 1) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Payload array
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_word;
        end
    end

endmodule

`default_nettype wire

//--- design/stream_interleaver.sv
`timescale 1ns/100ps
`default_nettype none

module stream_interleaver (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         in_valid [interleave_pkg::NUM_LANES],
    output logic                        in_ready [interleave_pkg::NUM_LANES],
    input  wire interleave_pkg::lane_word_t in_word [interleave_pkg::NUM_LANES],
    output logic                        out_valid,
    input  wire                         out_ready,
    output interleave_pkg::merged_word_t out_word
);

    // FIFO to merger streams
    logic                       fifo_valid [interleave_pkg::NUM_LANES];
    logic                       fifo_ready [interleave_pkg::NUM_LANES];
    interleave_pkg::lane_word_t fifo_word  [interleave_pkg::NUM_LANES];

    // One elastic FIFO per lane absorbs bursts while waiting for its turn
    for (genvar i = 0; i < interleave_pkg::NUM_LANES; i++) begin : g_lane
        lane_fifo u_fifo (
            .clock     (clock),
            .rst_n     (rst_n),
            .in_valid  (in_valid[i]),
            .in_ready  (in_ready[i]),
            .in_word   (in_word[i]),
            .out_valid (fifo_valid[i]),
            .out_ready (fifo_ready[i]),
            .out_word  (fifo_word[i])
        );
    end

    force_robin_merge u_merge (
        .clock      (clock),
        .rst_n      (rst_n),
        .lane_valid (fifo_valid),
        .lane_ready (fifo_ready),
        .lane_word  (fifo_word),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_word   (out_word)
    );

endmodule

`default_nettype wire

//--- sim/interleave_tests.txt
# Phase header: words_per_lane gap_mode(0 none,1 random,2 lane 2 late) ready_mode(0 always,1 random,2 stall)
# Data line: lane hex_data
2 0 0
0 a000
1 b000
2 c000
3 d000
0 a001
1 b001
2 c001
3 d001
2 2 0
0 1100
1 2100
2 3100
3 4100
0 1101
1 2101
2 3101
3 4101
3 1 1
0 5a00
1 6b00
2 7c00
3 8d00
0 5a01
1 6b01
2 7c01
3 8d01
0 5a02
1 6b02
2 7c02
3 8d02
2 0 2
0 0f0f
1 1e1e
2 2d2d
3 3c3c
0 4b4b
1 5a5a
2 6969
3 7878

//--- sim/stream_interleaver_tb.sv
`timescale 1ns/100ps
`default_nettype none

module stream_interleaver_tb;

    localparam int N = interleave_pkg::NUM_LANES;

    logic                         clock;
    logic                         rst_n;
    logic                         in_valid [N];
    logic                         in_ready [N];
    interleave_pkg::lane_word_t   in_word [N];
    logic                         out_valid;
    logic                         out_ready;
    interleave_pkg::merged_word_t out_word;

    integer      seed;
    int          data_errors;
    int          order_errors;
    int          timeouts;
    int          count;
    int          gap_mode;
    int          rdy_mode;
    int          sent [N];
    bit          lane2_offered;
    logic [15:0] words [N][$];

    stream_interleaver dut0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Skips blank lines and lines starting with #
    function automatic int next_line(input int fd, output string line);
        int code;
        line = "";
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                return 1;
            end
        end
        return 0;
    endfunction

    function automatic bit may_offer(input int lane, input int cycle);
        case (gap_mode)
            1:       return bit'($random(seed) & 1);
            2:       return (lane != 2) || (cycle > 30);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic pick_out_ready(input int cycle);
        case (rdy_mode)
            1:       return logic'($random(seed) & 1);
            2:       return (cycle > 30) ? logic'($random(seed) & 1) : 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    task automatic check_idle_outputs;
        if (out_valid !== 1'b0) begin
            $display("Error: out_valid got %h expected 0", out_valid);
            data_errors++;
        end
        for (int l = 0; l < N; l++) begin
            if (in_ready[l] !== 1'b0) begin
                $display("Error: in_ready[%0d] got %h expected 0", l, in_ready[l]);
                data_errors++;
            end
        end
    endtask

    task automatic run_phase;
        int                           total;
        int                           out_count;
        int                           in_total;
        int                           cycle;
        bit                           held_valid;
        interleave_pkg::merged_word_t held;
        logic [15:0]                  exp_data;
        logic [1:0]                   exp_lane;
        total         = count * N;
        out_count     = 0;
        in_total      = 0;
        cycle         = 0;
        held_valid    = 1'b0;
        held          = '0;
        lane2_offered = 1'b0;
        for (int l = 0; l < N; l++) begin
            sent[l] = 0;
        end
        while (out_count < total && cycle < 2000) begin
            @(posedge clock);
            cycle++;
            // Count inputs only on valid and ready
            for (int l = 0; l < N; l++) begin
                if (in_valid[l] && in_ready[l]) begin
                    sent[l]++;
                    in_total++;
                end
            end
            if (held_valid) begin
                if (!out_valid) begin
                    $display("out_valid dropped while the output was stalled");
                    data_errors++;
                end else if (out_word !== held) begin
                    $display("Error: out_word got %h expected %h", out_word, held);
                    data_errors++;
                end
            end
            held_valid = out_valid && !out_ready;
            held       = out_word;
            if (out_valid && out_ready) begin
                exp_lane = 2'(out_count % N);
                exp_data = words[out_count % N][out_count / N];
                if (out_word.lane !== exp_lane) begin
                    $display("Error: out_word.lane got %h expected %h", out_word.lane, exp_lane);
                    order_errors++;
                end
                if (out_word.data !== exp_data) begin
                    $display("Error: out_word.data got %h expected %h", out_word.data, exp_data);
                    data_errors++;
                end
                out_count++;
            end
            if (gap_mode == 2 && !lane2_offered && out_count > 2) begin
                $display("More than two words left before lane 2 was offered a word");
                order_errors++;
            end
            for (int l = 0; l < N; l++) begin
                if (in_valid[l] && !in_ready[l]) begin
                    // Hold the offered word until it transfers
                end else if (sent[l] < count && may_offer(l, cycle)) begin
                    in_valid[l]     <= 1'b1;
                    in_word[l].data <= words[l][sent[l]];
                    if (l == 2) begin
                        lane2_offered = 1'b1;
                    end
                end else begin
                    in_valid[l] <= 1'b0;
                end
            end
            out_ready <= pick_out_ready(cycle);
        end
        if (out_count < total) begin
            $display("Timed out waiting for output words, got %0d of %0d", out_count, total);
            timeouts++;
        end else begin
            if (in_total != total) begin
                $display("Input transfers counted %0d but %0d words came out", in_total, total);
                data_errors++;
            end
            @(posedge clock);
            if (out_valid) begin
                $display("An extra output word appeared after the phase ended");
                data_errors++;
            end
        end
    endtask

    initial begin
        string       line;
        int          fd;
        int          lane;
        int          cycle;
        bit          all_ready;
        logic [15:0] value;
        seed         = 99;
        data_errors  = 0;
        order_errors = 0;
        timeouts     = 0;
        rst_n        = 1'b0;
        out_ready    = 1'b0;
        for (int l = 0; l < N; l++) begin
            in_valid[l] = 1'b0;
            in_word[l]  = '0;
        end
        // Outputs are known only once the first edge has seen reset
        @(posedge clock);
        repeat (3) begin
            @(posedge clock);
            check_idle_outputs();
        end
        rst_n <= 1'b1;
        @(posedge clock);
        check_idle_outputs();

        cycle     = 0;
        all_ready = 1'b0;
        while (!all_ready && cycle < 20) begin
            @(posedge clock);
            cycle++;
            all_ready = 1'b1;
            for (int l = 0; l < N; l++) begin
                all_ready = all_ready & in_ready[l];
            end
        end
        if (!all_ready) begin
            $display("Timed out waiting for in_ready after reset");
            timeouts++;
        end

        fd = $fopen("sim/interleave_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file");
            timeouts++;
        end
        while (timeouts == 0 && next_line(fd, line)) begin
            void'($sscanf(line, "%d %d %d", count, gap_mode, rdy_mode));
            for (int l = 0; l < N; l++) begin
                words[l].delete();
            end
            for (int k = 0; k < count * N; k++) begin
                if (next_line(fd, line)) begin
                    void'($sscanf(line, "%d %h", lane, value));
                    words[lane].push_back(value);
                end
            end
            run_phase();
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Errors: data %0d, order %0d, timeouts %0d", data_errors, order_errors, timeouts);
        if (data_errors == 0 && order_errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/interleave_pkg.sv
design/lane_fifo.sv
design/force_robin_merge.sv
design/stream_interleaver.sv
sim/stream_interleaver_tb.sv
